// File: design/aiq_defines.svh
// AIQ sizing macros for entry count, pipe count and tag and id widths
`ifndef AIQ_DEFINES_SVH
`define AIQ_DEFINES_SVH

//========================================
// Queue geometry
//========================================
// Entries in the arithmetic issue queue
`define AIQ_ENTRIES 4
// Issue pipes, also the number of result broadcasts
`define AIQ_PIPES   2

// Physical register tag width
`define AIQ_PREG_W  6
// Instruction id width
`define AIQ_IID_W   5

`endif

// File: design/aiq_pkg.sv
// AIQ package with the vector, tag and id types shared by the queue blocks
`include "aiq_defines.svh"

package aiq_pkg;

  //========================================
  // Shared types
  //========================================
  // One bit per issue pipe
  // Launch-ready, broadcast readiness, entry ready
  typedef logic [`AIQ_PIPES-1:0]   pipe_vec_t;

  // Physical register tag
  typedef logic [`AIQ_PREG_W-1:0]  preg_t;

  // Instruction id
  typedef logic [`AIQ_IID_W-1:0]   iid_t;

  // One bit per entry
  // Valid, create select, grant, per-pipe ready masks
  typedef logic [`AIQ_ENTRIES-1:0] entry_vec_t;

endpackage

// File: design/aiq_src_lch_rdy.sv
// AIQ source launch-ready vector with create load, wakeup update and read bypass
`timescale 1ns/1ps

module aiq_src_lch_rdy
  import aiq_pkg::*;
(
  input  logic       y_clk,
  input  logic       cpurst_b,
  input  logic       vld,
  input  logic       create_en,
  input  pipe_vec_t  create_lch_rdy,
  input  logic [1:0] wake_hit,
  input  pipe_vec_t  wake0_rdy,
  input  pipe_vec_t  wake1_rdy,
  output pipe_vec_t  read_lch_rdy
);

  // Stored launch-ready, one bit per pipe
  pipe_vec_t lch_rdy;

  //========================================
  // Vector register
  //========================================
  // Create first, then broadcast 0, then broadcast 1
  // Wakeups only land while the entry stays valid
  always_ff @(posedge y_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      lch_rdy <= '0;
    else if (create_en)
      lch_rdy <= create_lch_rdy;
    else if (vld && wake_hit[0])
      lch_rdy <= wake0_rdy;
    else if (vld && wake_hit[1])
      lch_rdy <= wake1_rdy;
  end

  //========================================
  // Read port
  //========================================
  // Single hit bypasses the broadcast vector
  // Double hit or no hit shows the stored value
  always_comb
  begin
    case (wake_hit)
      2'b01:   read_lch_rdy = wake0_rdy;
      2'b10:   read_lch_rdy = wake1_rdy;
      default: read_lch_rdy = lch_rdy;
    endcase
  end

endmodule

// File: design/aiq_entry.sv
// AIQ entry holding id and source tags, matching broadcasts and forming pipe ready
`timescale 1ns/1ps

module aiq_entry
  import aiq_pkg::*;
(
  input  logic      y_clk,
  input  logic      cpurst_b,
  input  logic      create_en,
  input  iid_t      create_iid,
  input  preg_t     create_src0_preg,
  input  preg_t     create_src1_preg,
  input  pipe_vec_t create_src0_lch_rdy,
  input  pipe_vec_t create_src1_lch_rdy,
  input  logic      wake0_vld,
  input  preg_t     wake0_preg,
  input  pipe_vec_t wake0_rdy,
  input  logic      wake1_vld,
  input  preg_t     wake1_preg,
  input  pipe_vec_t wake1_rdy,
  input  logic      grant,
  output logic      vld,
  output iid_t      iid,
  output pipe_vec_t rdy
);

  // Source tags captured at create
  preg_t      src0_preg;
  preg_t      src1_preg;
  // Hit bits, index is the broadcast number
  logic [1:0] src0_hit;
  logic [1:0] src1_hit;
  // Read-port view of each source
  pipe_vec_t  src0_rdy;
  pipe_vec_t  src1_rdy;
  // Entry stays resident past this edge
  logic       hold_vld;

  //========================================
  // Valid and payload
  //========================================
  always_ff @(posedge y_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      vld <= 1'b0;
    else if (create_en)
      vld <= 1'b1;
    else if (grant)
      vld <= 1'b0;
  end

  // Payload loads only on create
  always_ff @(posedge y_clk)
  begin
    if (create_en)
    begin
      iid       <= create_iid;
      src0_preg <= create_src0_preg;
      src1_preg <= create_src1_preg;
    end
  end

  //========================================
  // Broadcast match
  //========================================
  assign src0_hit[0] = wake0_vld && vld && (wake0_preg == src0_preg);
  assign src0_hit[1] = wake1_vld && vld && (wake1_preg == src0_preg);
  assign src1_hit[0] = wake0_vld && vld && (wake0_preg == src1_preg);
  assign src1_hit[1] = wake1_vld && vld && (wake1_preg == src1_preg);

  // Granted entry leaves, so its vectors freeze
  assign hold_vld = vld && !grant;

  // Source 0 readiness
  aiq_src_lch_rdy u_src0_lch_rdy (
    .y_clk          (y_clk),
    .cpurst_b       (cpurst_b),
    .vld            (hold_vld),
    .create_en      (create_en),
    .create_lch_rdy (create_src0_lch_rdy),
    .wake_hit       (src0_hit),
    .wake0_rdy      (wake0_rdy),
    .wake1_rdy      (wake1_rdy),
    .read_lch_rdy   (src0_rdy)
  );

  // Source 1 readiness
  aiq_src_lch_rdy u_src1_lch_rdy (
    .y_clk          (y_clk),
    .cpurst_b       (cpurst_b),
    .vld            (hold_vld),
    .create_en      (create_en),
    .create_lch_rdy (create_src1_lch_rdy),
    .wake_hit       (src1_hit),
    .wake0_rdy      (wake0_rdy),
    .wake1_rdy      (wake1_rdy),
    .read_lch_rdy   (src1_rdy)
  );

  // Ready per pipe needs both sources
  assign rdy = vld ? (src0_rdy & src1_rdy) : '0;

endmodule

// File: design/aiq_alloc.sv
// AIQ allocator picking the lowest free entry for a create and flagging a full queue
`timescale 1ns/1ps

module aiq_alloc
  import aiq_pkg::*;
(
  input  logic       create_vld,
  input  entry_vec_t entry_vld,
  output entry_vec_t create_sel,
  output logic       create_full
);

  // Free entries
  entry_vec_t free_vec;
  // Lowest free entry, one-hot
  entry_vec_t free_low;

  //========================================
  // Free entry search
  //========================================
  assign free_vec = ~entry_vld;

  // Isolate lowest set bit, x & -x
  // Zero when nothing is free
  assign free_low = free_vec & (~free_vec + 1'b1);

  //========================================
  // Create select and full
  //========================================
  // Only the chosen entry sees the strobe
  // A full queue yields zero, so the create drops
  assign create_sel = create_vld ? free_low : '0;

  // Every entry occupied
  assign create_full = &entry_vld;

endmodule

// File: design/aiq_issue_sel.sv
// AIQ issue select granting up to two ready entries, one per pipe, with id mux
`timescale 1ns/1ps
`include "aiq_defines.svh"

module aiq_issue_sel
  import aiq_pkg::*;
(
  input  entry_vec_t entry_rdy0,
  input  entry_vec_t entry_rdy1,
  input  iid_t       entry_iid [`AIQ_ENTRIES],
  output entry_vec_t grant,
  output logic       issue0_vld,
  output iid_t       issue0_iid,
  output logic       issue1_vld,
  output iid_t       issue1_iid
);

  // One-hot grants per pipe
  entry_vec_t gnt0;
  entry_vec_t gnt1;
  // Pipe 1 candidates after pipe 0 pick
  entry_vec_t cand1;

  //========================================
  // Fixed-priority select
  //========================================
  // Pipe 0, lowest index ready for pipe 0
  assign gnt0 = entry_rdy0 & (~entry_rdy0 + 1'b1);

  // Pipe 1 skips the pipe 0 winner
  assign cand1 = entry_rdy1 & ~gnt0;
  assign gnt1  = cand1 & (~cand1 + 1'b1);

  // Entries leave on either grant
  assign grant = gnt0 | gnt1;

  //========================================
  // Issue outputs
  //========================================
  assign issue0_vld = |gnt0;
  assign issue1_vld = |gnt1;

  // AND-OR mux over one-hot grants
  always_comb
  begin
    issue0_iid = '0;
    issue1_iid = '0;
    for (int i = 0; i < `AIQ_ENTRIES; i++)
    begin
      issue0_iid = issue0_iid | ({`AIQ_IID_W{gnt0[i]}} & entry_iid[i]);
      issue1_iid = issue1_iid | ({`AIQ_IID_W{gnt1[i]}} & entry_iid[i]);
    end
  end

endmodule

// File: design/aiq_top.sv
// AIQ top level joining allocator, four entries and the two-pipe issue select
`timescale 1ns/1ps
`include "aiq_defines.svh"

module aiq_top
  import aiq_pkg::*;
(
  input  logic      y_clk,
  input  logic      cpurst_b,
  // Create group
  input  logic      create_vld,
  input  iid_t      create_iid,
  input  preg_t     create_src0_preg,
  input  preg_t     create_src1_preg,
  input  pipe_vec_t create_src0_lch_rdy,
  input  pipe_vec_t create_src1_lch_rdy,
  // Broadcast from pipe 0
  input  logic      wake0_vld,
  input  preg_t     wake0_preg,
  input  pipe_vec_t wake0_rdy,
  // Broadcast from pipe 1
  input  logic      wake1_vld,
  input  preg_t     wake1_preg,
  input  pipe_vec_t wake1_rdy,
  output logic      create_full,
  output logic      issue0_vld,
  output iid_t      issue0_iid,
  output logic      issue1_vld,
  output iid_t      issue1_iid
);

  // Per-entry state seen by alloc and select
  entry_vec_t entry_vld;
  entry_vec_t create_sel;
  entry_vec_t grant;
  entry_vec_t entry_rdy0;
  entry_vec_t entry_rdy1;
  iid_t       entry_iid [`AIQ_ENTRIES];
  pipe_vec_t  entry_rdy [`AIQ_ENTRIES];

  //========================================
  // Allocation
  //========================================
  aiq_alloc u_alloc (
    .create_vld  (create_vld),
    .entry_vld   (entry_vld),
    .create_sel  (create_sel),
    .create_full (create_full)
  );

  //========================================
  // Entries
  //========================================
  for (genvar i = 0; i < `AIQ_ENTRIES; i++)
  begin : g_entry
    aiq_entry u_entry (
      .y_clk               (y_clk),
      .cpurst_b            (cpurst_b),
      .create_en           (create_sel[i]),
      .create_iid          (create_iid),
      .create_src0_preg    (create_src0_preg),
      .create_src1_preg    (create_src1_preg),
      .create_src0_lch_rdy (create_src0_lch_rdy),
      .create_src1_lch_rdy (create_src1_lch_rdy),
      .wake0_vld           (wake0_vld),
      .wake0_preg          (wake0_preg),
      .wake0_rdy           (wake0_rdy),
      .wake1_vld           (wake1_vld),
      .wake1_preg          (wake1_preg),
      .wake1_rdy           (wake1_rdy),
      .grant               (grant[i]),
      .vld                 (entry_vld[i]),
      .iid                 (entry_iid[i]),
      .rdy                 (entry_rdy[i])
    );

    // Split per-pipe ready into masks
    assign entry_rdy0[i] = entry_rdy[i][0];
    assign entry_rdy1[i] = entry_rdy[i][1];
  end

  //========================================
  // Issue select
  //========================================
  aiq_issue_sel u_issue_sel (
    .entry_rdy0 (entry_rdy0),
    .entry_rdy1 (entry_rdy1),
    .entry_iid  (entry_iid),
    .grant      (grant),
    .issue0_vld (issue0_vld),
    .issue0_iid (issue0_iid),
    .issue1_vld (issue1_vld),
    .issue1_iid (issue1_iid)
  );

endmodule

// File: tb/aiq_checker.sv
// AIQ checker comparing issue outputs and queue full against expected values
`timescale 1ns/1ps

module aiq_checker
  import aiq_pkg::*;
(
  input  logic        y_clk,
  input  logic        cpurst_b,
  input  logic        chk_en,
  input  logic        issue0_vld,
  input  iid_t        issue0_iid,
  input  logic        issue1_vld,
  input  iid_t        issue1_iid,
  input  logic        create_full,
  input  logic        exp_issue0_vld,
  input  iid_t        exp_issue0_iid,
  input  logic        exp_issue1_vld,
  input  iid_t        exp_issue1_iid,
  input  logic        exp_full,
  output int unsigned chk_cnt,
  output int unsigned err_cnt
);

  // One field, X on the DUT side counts as wrong
  task automatic compare_field(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("FAIL %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  //========================================
  // Mid-cycle sampling
  //========================================
  // Inputs settle 1 ns after the rising edge
  always @(negedge y_clk)
  begin
    if (!cpurst_b)
    begin
      chk_cnt = 0;
      err_cnt = 0;
    end
    else if (chk_en)
    begin
      chk_cnt++;
      compare_field("issue0_vld", 8'(issue0_vld), 8'(exp_issue0_vld));
      // Ids only matter on a valid issue
      if (exp_issue0_vld)
        compare_field("issue0_iid", 8'(issue0_iid), 8'(exp_issue0_iid));
      compare_field("issue1_vld", 8'(issue1_vld), 8'(exp_issue1_vld));
      if (exp_issue1_vld)
        compare_field("issue1_iid", 8'(issue1_iid), 8'(exp_issue1_iid));
      compare_field("create_full", 8'(create_full), 8'(exp_full));
    end
  end

endmodule

// File: tb/aiq_asserts.sv
// AIQ concurrent assertions on issue ids, post-reset issue and queue full
`timescale 1ns/1ps

module aiq_asserts
  import aiq_pkg::*;
(
  input logic y_clk,
  input logic cpurst_b,
  input logic create_vld,
  input logic create_full,
  input logic issue0_vld,
  input iid_t issue0_iid,
  input logic issue1_vld,
  input iid_t issue1_iid
);

  int unsigned err_cnt = 0;
  // Occupancy, accepted creates minus issues
  logic [2:0]  occ;

  always_ff @(posedge y_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      occ <= '0;
    else
      occ <= occ + 3'(create_vld && !create_full) - 3'(issue0_vld) - 3'(issue1_vld);
  end

  //========================================
  // Properties
  //========================================
  // Both pipes never carry one instruction
  a_distinct_iid: assert property (@(posedge y_clk) disable iff (!cpurst_b)
    (issue0_vld && issue1_vld) |-> (issue0_iid != issue1_iid))
  else
  begin
    $error("Both issue pipes carry the same id");
    err_cnt++;
  end

  // Queue is empty right after reset
  a_reset_idle: assert property (@(posedge y_clk)
    $rose(cpurst_b) |-> (!issue0_vld && !issue1_vld))
  else
  begin
    $error("Issue valid in the first cycle after reset");
    err_cnt++;
  end

  // Full only with four resident entries
  a_full_occ: assert property (@(posedge y_clk) disable iff (!cpurst_b)
    create_full |-> (occ == 3'd4))
  else
  begin
    $error("create_full set with fewer than four entries");
    err_cnt++;
  end

endmodule

bind aiq_top aiq_asserts u_asserts (
  .y_clk       (y_clk),
  .cpurst_b    (cpurst_b),
  .create_vld  (create_vld),
  .create_full (create_full),
  .issue0_vld  (issue0_vld),
  .issue0_iid  (issue0_iid),
  .issue1_vld  (issue1_vld),
  .issue1_iid  (issue1_iid)
);

// File: tb/aiq_tb.sv
// AIQ testbench driving the queue from a stimulus file and reporting the run result
`timescale 1ns/1ps

module aiq_tb
  import aiq_pkg::*;
();

  // DUT inputs
  logic       y_clk;
  logic       cpurst_b;
  logic       create_vld;
  iid_t       create_iid;
  preg_t      create_src0_preg;
  preg_t      create_src1_preg;
  pipe_vec_t  create_src0_lch_rdy;
  pipe_vec_t  create_src1_lch_rdy;
  logic       wake0_vld;
  preg_t      wake0_preg;
  pipe_vec_t  wake0_rdy;
  logic       wake1_vld;
  preg_t      wake1_preg;
  pipe_vec_t  wake1_rdy;
  // DUT outputs
  logic       create_full;
  logic       issue0_vld;
  iid_t       issue0_iid;
  logic       issue1_vld;
  iid_t       issue1_iid;
  // Expected values for the current cycle
  logic       chk_en;
  logic       exp_issue0_vld;
  iid_t       exp_issue0_iid;
  logic       exp_issue1_vld;
  iid_t       exp_issue1_iid;
  logic       exp_full;
  int unsigned chk_cnt;
  int unsigned err_cnt;
  int unsigned file_err;
  // Stimulus lines and the fields of the current one
  string      lines [$];
  logic [7:0] fld [18];

  //========================================
  // Clock and DUT
  //========================================
  always #50 y_clk = ~y_clk;

  aiq_top uut (.*);

  aiq_checker u_checker (.*);

  // Quiet inputs and no expected issue
  task automatic drive_idle(input logic full);
    create_vld          = 1'b0;
    create_iid          = '0;
    create_src0_preg    = '0;
    create_src1_preg    = '0;
    create_src0_lch_rdy = '0;
    create_src1_lch_rdy = '0;
    wake0_vld           = 1'b0;
    wake0_preg          = '0;
    wake0_rdy           = '0;
    wake1_vld           = 1'b0;
    wake1_preg          = '0;
    wake1_rdy           = '0;
    exp_issue0_vld      = 1'b0;
    exp_issue0_iid      = '0;
    exp_issue1_vld      = 1'b0;
    exp_issue1_iid      = '0;
    exp_full            = full;
  endtask

  // Split one text line into its 18 hex fields
  task automatic load_fields(input string s);
    int n;
    n = $sscanf(s, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
                fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
                fld[17]);
    if (n != 18)
    begin
      $display("Malformed stimulus line, %0d fields read: %s", n, s);
      file_err++;
    end
  endtask

  // Apply the loaded fields to the DUT and the checker
  task automatic drive_fields();
    create_vld          = fld[1][0];
    create_iid          = iid_t'(fld[2]);
    create_src0_preg    = preg_t'(fld[3]);
    create_src1_preg    = preg_t'(fld[4]);
    create_src0_lch_rdy = pipe_vec_t'(fld[5]);
    create_src1_lch_rdy = pipe_vec_t'(fld[6]);
    wake0_vld           = fld[7][0];
    wake0_preg          = preg_t'(fld[8]);
    wake0_rdy           = pipe_vec_t'(fld[9]);
    wake1_vld           = fld[10][0];
    wake1_preg          = preg_t'(fld[11]);
    wake1_rdy           = pipe_vec_t'(fld[12]);
    exp_issue0_vld      = fld[13][0];
    exp_issue0_iid      = iid_t'(fld[14]);
    exp_issue1_vld      = fld[15][0];
    exp_issue1_iid      = iid_t'(fld[16]);
    exp_full            = fld[17][0];
    chk_en              = 1'b1;
  endtask

  //========================================
  // Main sequence
  //========================================
  initial
  begin
    int          fd;
    int          n_idle;
    int          wd_cycles;
    int unsigned total;
    string       line;
    void'($urandom(32'h6bf5129a));
    y_clk    = 1'b0;
    cpurst_b = 1'b0;
    chk_en   = 1'b0;
    file_err = 0;
    drive_idle(1'b0);

    // Whole file read first since its length sizes the watchdog
    fd = $fopen("tb/aiq_input.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file tb/aiq_input.txt");
      file_err++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#")
          lines.push_back(line);
      end
      $fclose(fd);
    end

    // Up to two jitter cycles per line
    wd_cycles = 3 * lines.size() + 2 + 20;
    fork
      begin
        #(wd_cycles * 100);
        $display("Timeout, run still busy after %0d clock periods", wd_cycles);
        $display("CHECKS FAILED");
        $finish;
      end
    join_none

    repeat (2) @(posedge y_clk);
    #1 cpurst_b = 1'b1;

    foreach (lines[k])
    begin
      load_fields(lines[k]);
      // Jitter only where the queue has nothing ready
      if (fld[0][0])
      begin
        n_idle = $urandom_range(2, 0);
        repeat (n_idle)
        begin
          @(posedge y_clk);
          #1;
          drive_idle(fld[17][0]);
          chk_en = 1'b1;
        end
      end
      @(posedge y_clk);
      #1;
      drive_fields();
    end

    @(posedge y_clk);
    #1;
    chk_en = 1'b0;
    total  = err_cnt + uut.u_asserts.err_cnt + file_err;
    $display("Checks %0d, compare errors %0d, assertion errors %0d, file errors %0d",
             chk_cnt, err_cnt, uut.u_asserts.err_cnt, file_err);
    if (total == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: tb/aiq_input.txt
# gap cvld iid s0 s1 s0rdy s1rdy w0vld w0preg w0rdy w1vld w1preg w1rdy
#   then expected i0vld i0iid i1vld i1iid full, all hex, one line per cycle
1 1 01 01 02 1 1 0 00 0 0 00 0 0 00 0 00 0
0 0 00 00 00 0 0 0 00 0 0 00 0 1 01 0 00 0
1 1 02 03 04 0 3 0 00 0 0 00 0 0 00 0 00 0
1 0 00 00 00 0 0 0 00 0 0 00 0 0 00 0 00 0
1 0 00 00 00 0 0 1 03 2 0 00 0 0 00 1 02 0
1 1 03 05 06 0 3 0 00 0 0 00 0 0 00 0 00 0
1 0 00 00 00 0 0 1 05 3 1 05 1 0 00 0 00 0
0 0 00 00 00 0 0 0 00 0 0 00 0 1 03 0 00 0
1 1 04 07 08 0 3 0 00 0 0 00 0 0 00 0 00 0
1 1 05 07 09 0 3 0 00 0 0 00 0 0 00 0 00 0
1 1 06 07 0a 0 3 0 00 0 0 00 0 0 00 0 00 0
1 0 00 00 00 0 0 1 07 3 0 00 0 1 04 1 05 0
0 0 00 00 00 0 0 0 00 0 0 00 0 1 06 0 00 0
1 1 07 0b 0c 0 0 0 00 0 0 00 0 0 00 0 00 0
1 1 08 0b 0c 0 0 0 00 0 0 00 0 0 00 0 00 0
1 1 09 0b 0c 0 0 0 00 0 0 00 0 0 00 0 00 0
1 1 0a 0b 0c 0 0 0 00 0 0 00 0 0 00 0 00 0
1 1 0b 0d 0d 3 3 0 00 0 0 00 0 0 00 0 00 1
1 0 00 00 00 0 0 1 0b 3 1 0c 3 1 07 1 08 1
0 0 00 00 00 0 0 0 00 0 0 00 0 1 09 1 0a 0
1 0 00 00 00 0 0 0 00 0 0 00 0 0 00 0 00 0

// File: src.f
+incdir+design
design/aiq_pkg.sv
design/aiq_src_lch_rdy.sv
design/aiq_entry.sv
design/aiq_alloc.sv
design/aiq_issue_sel.sv
design/aiq_top.sv
tb/aiq_checker.sv
tb/aiq_asserts.sv
tb/aiq_tb.sv

// File: Bender.yml
package:
  name: aiq

sources:
  - include_dirs:
      - design
    files:
      - design/aiq_pkg.sv
      - design/aiq_src_lch_rdy.sv
      - design/aiq_entry.sv
      - design/aiq_alloc.sv
      - design/aiq_issue_sel.sv
      - design/aiq_top.sv
  - target: test
    files:
      - tb/aiq_checker.sv
      - tb/aiq_asserts.sv
      - tb/aiq_tb.sv
